//--- list.f
core_general_pkg.sv
isa_pkg.sv
phase_sequencer.sv
instr_decoder.sv
register_file.sv
alu.sv
rv_exec_core.sv
rv_exec_core_chk.sv
tb_rv_exec_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_exec_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the simulation output
run: build
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_rv_exec_core.sv
`timescale 1ns/1ps

module tb_rv_exec_core;

    localparam logic [1:0] K_MODEL   = 2'd0;    // expected from reference model
    localparam logic [1:0] K_FIXED   = 2'd1;    // expected data held in the row
    localparam logic [1:0] K_ILLEGAL = 2'd2;
    localparam logic [1:0] K_BUSY    = 2'd3;    // second strobe while busy
    localparam int         TIMEOUT   = 20;

    typedef struct packed {
        core_general_pkg::inst_t inst;
        logic [1:0]              kind;
        core_general_pkg::word_t exp_data;
    } row_t;

    logic                       clk;
    logic                       rst_n;
    core_general_pkg::inst_t    inst;
    logic                       inst_valid;
    logic                       busy;
    logic                       retire;
    core_general_pkg::reg_idx_t retire_rd;
    core_general_pkg::word_t    retire_data;
    logic                       retire_illegal;

    row_t                    rows [$];
    core_general_pkg::word_t ref_regs [32];    // reference copy of x0..x31
    core_general_pkg::word_t lfsr_state;

    rv_exec_core #(
        .NREGS (32)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst           (inst),
        .inst_valid     (inst_valid),
        .busy           (busy),
        .retire         (retire),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_illegal (retire_illegal)
    );

    bind rv_exec_core rv_exec_core_chk chk0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_valid      (inst_valid),
        .busy            (busy),
        .retire          (retire),
        .phase_decode    (phase_decode),
        .phase_execute   (phase_execute),
        .phase_writeback (phase_writeback)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic lfsr_next_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (out ? 32'hA300_0000 : 32'h0);
        return out;
    endfunction

    function automatic core_general_pkg::word_t rand_bits(input int n);
        core_general_pkg::word_t v;
        v = '0;
        for (int k = 0; k < n; k++)
            v = {v[30:0], lfsr_next_bit()};    // one step per bit
        return v;
    endfunction

    function automatic core_general_pkg::inst_t r_type_word(
        input logic [6:0] f7, input core_general_pkg::reg_idx_t rs2,
        input core_general_pkg::reg_idx_t rs1, input logic [2:0] f3,
        input core_general_pkg::reg_idx_t rd
    );
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic core_general_pkg::inst_t i_type_word(
        input core_general_pkg::word_t imm, input core_general_pkg::reg_idx_t rs1,
        input logic [2:0] f3, input core_general_pkg::reg_idx_t rd
    );
        return {imm[11:0], rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic core_general_pkg::inst_t lui_word(
        input core_general_pkg::word_t upper, input core_general_pkg::reg_idx_t rd
    );
        return {upper[19:0], rd, 7'b0110111};
    endfunction

    function automatic core_general_pkg::reg_idx_t pick_src();
        return core_general_pkg::reg_idx_t'(rand_bits(3) + 32'd1);     // x1..x8
    endfunction

    function automatic core_general_pkg::reg_idx_t pick_dst();
        return core_general_pkg::reg_idx_t'(rand_bits(3) + 32'd9);     // x9..x16
    endfunction

    // RV32I semantics straight from the ISA rules
    function automatic core_general_pkg::word_t model_exec(input core_general_pkg::inst_t i);
        core_general_pkg::word_t a;
        core_general_pkg::word_t b;
        logic [4:0]              sh;
        a  = ref_regs[i[19:15]];
        b  = (i[6:0] == 7'b0010011) ? {{20{i[31]}}, i[31:20]} : ref_regs[i[24:20]];
        sh = b[4:0];
        if (i[6:0] == 7'b0110111)
            return {i[31:12], 12'h000};
        case (i[14:12])
            3'd0:    return (i[6:0] == 7'b0110011 && i[30]) ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return i[30] ? core_general_pkg::word_t'($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_row(input core_general_pkg::inst_t i, input logic [1:0] kind,
                           input core_general_pkg::word_t exp_data);
        rows.push_back('{inst: i, kind: kind, exp_data: exp_data});
    endtask

    task automatic build_table();
        core_general_pkg::reg_idx_t rs1;
        core_general_pkg::reg_idx_t rd;
        add_row(r_type_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd5), K_FIXED, 32'h0);
        for (int r = 1; r <= 8; r++)
        begin
            rd = core_general_pkg::reg_idx_t'(r);
            add_row(lui_word(rand_bits(20), rd), K_MODEL, '0);
            add_row(i_type_word(rand_bits(12), rd, 3'd0, rd), K_MODEL, '0);
        end
        for (int f3 = 0; f3 < 8; f3++)
            add_row(r_type_word(7'h00, pick_src(), pick_src(), 3'(f3), pick_dst()),
                    K_MODEL, '0);
        add_row(r_type_word(7'h20, pick_src(), pick_src(), 3'd0, pick_dst()), K_MODEL, '0);
        add_row(r_type_word(7'h20, pick_src(), pick_src(), 3'd5, pick_dst()), K_MODEL, '0);
        for (int f3 = 0; f3 < 8; f3++)
        begin
            rs1 = pick_src();
            rd  = pick_dst();
            if (f3 == 1 || f3 == 5)
                add_row(i_type_word(rand_bits(5), rs1, 3'(f3), rd), K_MODEL, '0);  // shamt
            else
                add_row(i_type_word(rand_bits(12), rs1, 3'(f3), rd), K_MODEL, '0);
        end
        add_row(i_type_word(32'h400 | rand_bits(5), pick_src(), 3'd5, pick_dst()), K_MODEL, '0);
        add_row(i_type_word(32'h055, 5'd1, 3'd0, 5'd0), K_MODEL, '0);      // x0 target
        add_row(r_type_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd12), K_MODEL, '0);
        add_row({12'h010, 5'd1, 3'd2, 5'd3, 7'b0000011}, K_ILLEGAL, '0);    // load opcode
        add_row(r_type_word(7'h20, 5'd2, 5'd1, 3'd4, 5'd4), K_ILLEGAL, '0);
        add_row(r_type_word(7'h00, 5'd0, 5'd3, 3'd0, 5'd13), K_MODEL, '0);
        add_row(r_type_word(7'h00, 5'd0, 5'd4, 3'd0, 5'd14), K_MODEL, '0);
        add_row(i_type_word(32'h02a, 5'd0, 3'd0, 5'd6), K_BUSY, '0);
        add_row(r_type_word(7'h00, 5'd0, 5'd7, 3'd0, 5'd15), K_MODEL, '0);  // x7 untouched
        add_row(r_type_word(7'h00, 5'd0, 5'd6, 3'd0, 5'd16), K_MODEL, '0);
    endtask

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input core_general_pkg::word_t got,
                              input core_general_pkg::word_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERROR: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_idx(input string name, input core_general_pkg::reg_idx_t got,
                             input core_general_pkg::reg_idx_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERROR: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERROR: %s got %h expected %h", name, got, exp));
    endtask

    task automatic run_row(input row_t r);
        core_general_pkg::word_t    exp_data;
        core_general_pkg::reg_idx_t rd;
        logic                       exp_ill;
        int                         cycles;
        rd       = r.inst[11:7];
        exp_ill  = (r.kind == K_ILLEGAL);
        exp_data = (r.kind == K_FIXED) ? r.exp_data : model_exec(r.inst);
        @(posedge clk);
        #5;
        inst       = r.inst;
        inst_valid = 1'b1;
        @(posedge clk);                         // accepted at this edge
        #5;
        if (r.kind == K_BUSY)
            inst = i_type_word(32'h7ff, 5'd0, 3'd0, 5'd7);
        else
            inst_valid = 1'b0;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
            if (cycles == 1 && r.kind == K_BUSY)
            begin
                @(posedge clk);
                #5;
                inst_valid = 1'b0;
            end
            if (cycles > TIMEOUT)
                stop_with_failure("timeout waiting for retire");
        end
        while (!retire);
        if (cycles != 3)
            stop_with_failure($sformatf("retire came %0d cycles after acceptance, not 3",
                                        cycles));
        check_bit("retire_illegal", retire_illegal, exp_ill);
        check_idx("retire_rd", retire_rd, rd);
        if (!exp_ill)
            check_word("retire_data", retire_data, exp_data);
        if (!exp_ill && rd != 5'd0)
            ref_regs[rd] = exp_data;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                stop_with_failure("timeout waiting for busy to drop");
        end
        while (busy);
        if (cycles != 1)
            stop_with_failure("busy stayed high after the retire cycle");
    endtask

    initial
    begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        lfsr_state = 32'h3ff7;
        foreach (ref_regs[n])
            ref_regs[n] = '0;
        build_table();
        repeat (4) @(posedge clk);
        #5;
        rst_n = 1'b1;
        foreach (rows[n])
            run_row(rows[n]);
        if (dut0.chk0.fail_count == 0)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            $display("Testbench failed");
            $fatal(1);
        end
    end

endmodule

//--- rv_exec_core_chk.sv
`timescale 1ns/1ps

module rv_exec_core_chk (
    input logic clk,
    input logic rst_n,
    input logic inst_valid,
    input logic busy,
    input logic retire,
    input logic phase_decode,
    input logic phase_execute,
    input logic phase_writeback
);

    int fail_count = 0;                         // read by the testbench at the end

    ////////////////////////////////////////////////////////////
    // phase and retire timing
    ////////////////////////////////////////////////////////////

    a_retire_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        (inst_valid && !busy) |-> ##3 retire    // fixed 3-cycle latency
    )
    else
    begin
        fail_count++;
        $error("retire did not follow acceptance after 3 cycles");
    end

    a_phase_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        phase_decode |=> phase_execute ##1 phase_writeback
    )
    else
    begin
        fail_count++;
        $error("phases did not step decode, execute, writeback");
    end

    a_idle_after_retire: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire |=> !busy                        // back to idle after writeback
    )
    else
    begin
        fail_count++;
        $error("busy still high one cycle after retire");
    end

endmodule

//--- rv_exec_core.sv
`timescale 1ns/1ps

module rv_exec_core #(
    parameter int NREGS = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  core_general_pkg::inst_t    inst,
    input  logic                       inst_valid,
    output logic                       busy,
    output logic                       retire,
    output core_general_pkg::reg_idx_t retire_rd,
    output core_general_pkg::word_t    retire_data,
    output logic                       retire_illegal
);

    core_general_pkg::inst_t    inst_q;
    logic                       phase_decode;
    logic                       phase_execute;
    logic                       phase_writeback;
    core_general_pkg::reg_idx_t rs1sel;
    core_general_pkg::reg_idx_t rs2sel;
    core_general_pkg::reg_idx_t rdsel;
    core_general_pkg::word_t    imm;
    logic                       use_imm;
    isa_pkg::alu_op_t           alu_op;
    logic                       illegal;
    core_general_pkg::word_t    rs1data;
    core_general_pkg::word_t    rs2data;
    core_general_pkg::word_t    result;

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    phase_sequencer u_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst            (inst),
        .inst_valid      (inst_valid),
        .inst_q          (inst_q),
        .phase_decode    (phase_decode),
        .phase_execute   (phase_execute),
        .phase_writeback (phase_writeback),
        .busy            (busy)
    );

    instr_decoder u_dec (
        .inst_q  (inst_q),
        .rs1sel  (rs1sel),
        .rs2sel  (rs2sel),
        .rdsel   (rdsel),
        .imm     (imm),
        .use_imm (use_imm),
        .alu_op  (alu_op),
        .illegal (illegal)
    );

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    register_file #(
        .NREGS (NREGS)
    ) u_rf (
        .clk             (clk),
        .rst_n           (rst_n),
        .rddata_wr       (result),
        .rdsel_wr        (rdsel),
        .phase_writeback (phase_writeback),
        .wr_inhibit      (illegal),         // illegal ops write nothing
        .rs1sel          (rs1sel),
        .rs2sel          (rs2sel),
        .rs1data_rd      (rs1data),
        .rs2data_rd      (rs2data)
    );

    alu u_alu (
        .clk           (clk),
        .rst_n         (rst_n),
        .phase_execute (phase_execute),
        .op_a          (rs1data),
        .rs2data       (rs2data),
        .imm           (imm),
        .use_imm       (use_imm),
        .alu_op        (alu_op),
        .result        (result)
    );

    // retire reported in the writeback cycle itself
    assign retire         = phase_writeback;
    assign retire_rd      = rdsel;
    assign retire_data    = result;
    assign retire_illegal = illegal;

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    phase_execute,
    input  core_general_pkg::word_t op_a,
    input  core_general_pkg::word_t rs2data,
    input  core_general_pkg::word_t imm,
    input  logic                    use_imm,
    input  isa_pkg::alu_op_t        alu_op,
    output core_general_pkg::word_t result
);

    core_general_pkg::word_t op_b;
    core_general_pkg::word_t alu_out;
    logic [4:0]              shamt;

    assign op_b  = use_imm ? imm : rs2data;
    assign shamt = op_b[4:0];               // shifts use low 5 bits only

    always_comb
    begin
        case (alu_op)
            isa_pkg::ALU_ADD:    alu_out = op_a + op_b;
            isa_pkg::ALU_SUB:    alu_out = op_a - op_b;
            isa_pkg::ALU_SLL:    alu_out = op_a << shamt;
            isa_pkg::ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            isa_pkg::ALU_SLTU:   alu_out = {31'b0, op_a < op_b};
            isa_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            isa_pkg::ALU_SRL:    alu_out = op_a >> shamt;
            isa_pkg::ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
            isa_pkg::ALU_OR:     alu_out = op_a | op_b;
            isa_pkg::ALU_AND:    alu_out = op_a & op_b;
            isa_pkg::ALU_PASS_B: alu_out = op_b;
            default:             alu_out = '0;
        endcase
    end

    // loaded at the edge closing the execute phase
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            result <= '0;
        else if (phase_execute)
            result <= alu_out;
    end

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file #(
    parameter int NREGS = 32                // 16 for RV32E
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  core_general_pkg::word_t    rddata_wr,
    input  core_general_pkg::reg_idx_t rdsel_wr,
    input  logic                       phase_writeback,
    input  logic                       wr_inhibit,
    input  core_general_pkg::reg_idx_t rs1sel,
    input  core_general_pkg::reg_idx_t rs2sel,
    output core_general_pkg::word_t    rs1data_rd,
    output core_general_pkg::word_t    rs2data_rd
);

    core_general_pkg::word_t regs [1:NREGS-1];  // x0 has no storage
    logic                    wr_en;

    assign wr_en = phase_writeback && !wr_inhibit;

    ////////////////////////////////////////////////////////////
    // x1 .. x(NREGS-1)
    ////////////////////////////////////////////////////////////

    for (genvar i = 1; i < NREGS; i++)
    begin : g_reg
        always_ff @(posedge clk)
        begin
            if (!rst_n)
                regs[i] <= '0;
            else if (wr_en && rdsel_wr == core_general_pkg::reg_idx_t'(i))
                regs[i] <= rddata_wr;       // out-of-range rd matches nothing
        end
    end

    // x0 and indices past NREGS read as zero
    function automatic core_general_pkg::word_t read_reg(
        input core_general_pkg::reg_idx_t sel
    );
        if (sel == '0 || int'(sel) >= NREGS)
            return '0;
        return regs[sel];
    endfunction

    always_comb
    begin
        rs1data_rd = read_reg(rs1sel);
        rs2data_rd = read_reg(rs2sel);
    end

endmodule

//--- instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  core_general_pkg::inst_t    inst_q,
    output core_general_pkg::reg_idx_t rs1sel,
    output core_general_pkg::reg_idx_t rs2sel,
    output core_general_pkg::reg_idx_t rdsel,
    output core_general_pkg::word_t    imm,
    output logic                       use_imm,
    output isa_pkg::alu_op_t           alu_op,
    output logic                       illegal
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    core_general_pkg::word_t i_imm;
    core_general_pkg::word_t u_imm;
    isa_pkg::alu_op_t        f3_op;

    assign opcode = inst_q[6:0];
    assign funct3 = inst_q[14:12];
    assign funct7 = inst_q[31:25];

    assign rdsel  = inst_q[11:7];
    assign rs1sel = inst_q[19:15];
    assign rs2sel = inst_q[24:20];

    assign i_imm = {{20{inst_q[31]}}, inst_q[31:20]};  // sign extended
    assign u_imm = {inst_q[31:12], 12'h000};

    // base operation shared by OP and OP-IMM
    always_comb
    begin
        case (funct3)
            isa_pkg::F3_ADD_SUB: f3_op = isa_pkg::ALU_ADD;
            isa_pkg::F3_SLL:     f3_op = isa_pkg::ALU_SLL;
            isa_pkg::F3_SLT:     f3_op = isa_pkg::ALU_SLT;
            isa_pkg::F3_SLTU:    f3_op = isa_pkg::ALU_SLTU;
            isa_pkg::F3_XOR:     f3_op = isa_pkg::ALU_XOR;
            isa_pkg::F3_SRL_SRA: f3_op = isa_pkg::ALU_SRL;
            isa_pkg::F3_OR:      f3_op = isa_pkg::ALU_OR;
            default:             f3_op = isa_pkg::ALU_AND;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // opcode / funct7 legality
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        imm     = i_imm;
        use_imm = 1'b0;
        alu_op  = f3_op;
        illegal = 1'b0;
        case (opcode)
            isa_pkg::OPC_OP:
            begin
                if (funct7 == isa_pkg::F7_ALT && funct3 == isa_pkg::F3_ADD_SUB)
                    alu_op = isa_pkg::ALU_SUB;
                else if (funct7 == isa_pkg::F7_ALT && funct3 == isa_pkg::F3_SRL_SRA)
                    alu_op = isa_pkg::ALU_SRA;
                else if (funct7 != isa_pkg::F7_BASE)
                    illegal = 1'b1;         // e.g. SUB's funct7 on XOR
            end
            isa_pkg::OPC_OP_IMM:
            begin
                use_imm = 1'b1;
                if (funct3 == isa_pkg::F3_SLL && funct7 != isa_pkg::F7_BASE)
                    illegal = 1'b1;
                else if (funct3 == isa_pkg::F3_SRL_SRA)
                begin
                    if (funct7 == isa_pkg::F7_ALT)
                        alu_op = isa_pkg::ALU_SRA;
                    else if (funct7 != isa_pkg::F7_BASE)
                        illegal = 1'b1;
                end
            end
            isa_pkg::OPC_LUI:
            begin
                imm     = u_imm;
                use_imm = 1'b1;
                alu_op  = isa_pkg::ALU_PASS_B;
            end
            default:
                illegal = 1'b1;             // anything outside the subset
        endcase
    end

endmodule

//--- phase_sequencer.sv
`timescale 1ns/1ps

module phase_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  core_general_pkg::inst_t inst,
    input  logic                    inst_valid,
    output core_general_pkg::inst_t inst_q,
    output logic                    phase_decode,
    output logic                    phase_execute,
    output logic                    phase_writeback,
    output logic                    busy
);

    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        EXECUTE,
        WRITEBACK
    } phase_t;

    phase_t state;
    phase_t state_next;
    logic   accept;

    assign accept = inst_valid && (state == IDLE);  // strobes while busy are dropped

    ////////////////////////////////////////////////////////////
    // phase stepping
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (state)
            IDLE:      state_next = accept ? DECODE : IDLE;
            DECODE:    state_next = EXECUTE;
            EXECUTE:   state_next = WRITEBACK;
            WRITEBACK: state_next = IDLE;   // register write lands here
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            inst_q <= inst;                 // held until the next accept
    end

    assign phase_decode    = (state == DECODE);
    assign phase_execute   = (state == EXECUTE);
    assign phase_writeback = (state == WRITEBACK);
    assign busy            = (state != IDLE);

endmodule

//--- isa_pkg.sv
package isa_pkg;

    ////////////////////////////////////////////////////////////
    // major opcodes, bits [6:0]
    ////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,    // register-register ALU
        OPC_OP_IMM = 7'b0010011,    // register-immediate ALU
        OPC_LUI    = 7'b0110111     // load upper immediate
    } opcode_t;

    ////////////////////////////////////////////////////////////
    // funct3 / funct7
    ////////////////////////////////////////////////////////////

    localparam logic [2:0] F3_ADD_SUB = 3'b000;  // ADDI has no SUB form
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;  // split by funct7
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10              // LUI result is the immediate
    } alu_op_t;

endpackage

//--- core_general_pkg.sv
package core_general_pkg;

    ////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN      = 32;  // RV32 only
    localparam int REG_IDX_W = 5;   // rs1, rs2, rd fields
    localparam int INST_W    = 32;  // no compressed forms

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic [XLEN-1:0]      word_t;     // one register value
    typedef logic [REG_IDX_W-1:0] reg_idx_t;  // register number
    typedef logic [INST_W-1:0]    inst_t;     // raw instruction word

endpackage
